// File: bench/tb_apb_mem.sv
// APB completer model for the load/store unit testbench
// 256-word memory with byte-lane writes, random wait states per transfer
// and an error region at every address with bit 11 set

`timescale 1ns/100ps

module tb_apb_mem
#(
   parameter logic [31:0] SEED = 32'hea22
)
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic [11:0]        paddr,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  lsu_pkg::lsu_data_t pwdata,
   input  lsu_pkg::lsu_strb_t pstrb,
   output logic               pready,
   output lsu_pkg::lsu_data_t prdata,
   output logic               pslverr
);
   lsu_pkg::lsu_data_t mem [256];
   logic [1:0]         wait_cnt;
   logic [31:0]        lfsr;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   // Fill pattern built from every bit of the word index
   initial
   begin
      logic [7:0] a;
      lfsr = SEED;
      for (int i = 0; i < 256; i++)
      begin
         a      = 8'(i);
         mem[i] = {a, ~a, a ^ 8'h5a, a + 8'h3c};
      end
   end

   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         wait_cnt <= 2'd0;
      else
      begin
         // Wait count chosen in the setup cycle
         if (psel && !penable)
            wait_cnt <= 2'(take_bits(2));
         else if (psel && penable && wait_cnt != 2'd0)
            wait_cnt <= wait_cnt - 2'd1;
         if (psel && penable && pready && pwrite && !paddr[11])
         begin
            for (int b = 0; b < 4; b++)
               if (pstrb[b])
                  mem[paddr[9:2]][8*b +: 8] <= pwdata[8*b +: 8];
         end
      end
   end

   assign pready  = psel && penable && (wait_cnt == 2'd0);
   assign pslverr = psel && penable && paddr[11];
   assign prdata  = (psel && penable && !pwrite && !paddr[11]) ? mem[paddr[9:2]] : '0;

endmodule

// File: bench/tb_lsu_top.sv
// Testbench for the load/store unit
// Directed and random requests against a reference model with a shadow
// memory, checking APB transfers and writeback records in order

`timescale 1ns/100ps

module tb_lsu_top;

   localparam int ADDR_W          = 12;
   localparam int CLK_PERIOD      = 4;
   localparam int N_DIRECTED      = 34;
   localparam int N_RANDOM        = 200;
   localparam int N_REQ           = N_DIRECTED + N_RANDOM;
   localparam int WATCHDOG_CYCLES = N_REQ * 20 + 4;

   // One expected APB transfer
   typedef struct packed {
      logic               write;
      logic [ADDR_W-1:0]  addr;
      lsu_pkg::lsu_strb_t strb;
      lsu_pkg::lsu_data_t wdata;
   } bus_xfer_t;

   logic               clk = 1'b0;
   logic               arst_n;
   logic               req_valid;
   lsu_pkg::lsu_req_t  req;
   logic               lsu_stall;
   logic [ADDR_W-1:0]  paddr;
   logic               psel;
   logic               penable;
   logic               pwrite;
   lsu_pkg::lsu_data_t pwdata;
   lsu_pkg::lsu_strb_t pstrb;
   logic               pready;
   lsu_pkg::lsu_data_t prdata;
   logic               pslverr;
   logic               wb_valid;
   lsu_pkg::lsu_wb_t   wb;

   lsu_pkg::lsu_data_t shadow [256];
   lsu_pkg::lsu_wb_t   exp_q[$];
   bus_xfer_t          bus_q[$];
   logic [31:0]        lfsr;

   lsu_top #(.ADDR_W(ADDR_W)) u_lsu_top
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .req_valid (req_valid),
      .req       (req),
      .lsu_stall (lsu_stall),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .pstrb     (pstrb),
      .pready    (pready),
      .prdata    (prdata),
      .pslverr   (pslverr),
      .wb_valid  (wb_valid),
      .wb        (wb)
   );

   tb_apb_mem #(.SEED(32'hea22)) u_mem
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .pstrb   (pstrb),
      .pready  (pready),
      .prdata  (prdata),
      .pslverr (pslverr)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "run stopped on error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         stop_run($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
   endtask

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   // Bytes covered by an access of this size
   function automatic int size_bytes(input lsu_pkg::lsu_size_t size);
      case (size)
         lsu_pkg::SIZE_BYTE: return 1;
         lsu_pkg::SIZE_HALF: return 2;
         lsu_pkg::SIZE_WORD: return 4;
         default:            return 0;
      endcase
   endfunction

   // An access must start on a multiple of its own size
   function automatic logic misaligned(input lsu_pkg::lsu_size_t size, input logic [31:0] a);
      int n;
      n = size_bytes(size);
      return (n != 0) && ((int'(a[1:0]) % n) != 0);
   endfunction

   // Lanes from the first addressed byte for the size of the access
   function automatic lsu_pkg::lsu_strb_t lane_strobe(input lsu_pkg::lsu_size_t size,
                                                      input logic [31:0] a);
      lsu_pkg::lsu_strb_t s;
      int                 n;
      n = size_bytes(size);
      s = '0;
      for (int i = 0; i < 4; i++)
         if ((i >= int'(a[1:0])) && (i < int'(a[1:0]) + n))
            s[i] = 1'b1;
      return s;
   endfunction

   function automatic logic [31:0] replicate(input lsu_pkg::lsu_req_t r);
      case (r.size)
         lsu_pkg::SIZE_BYTE: return {4{r.wdata[7:0]}};
         lsu_pkg::SIZE_HALF: return {2{r.wdata[15:0]}};
         default:            return r.wdata;
      endcase
   endfunction

   // Reference model for one writeback record
   function automatic lsu_pkg::lsu_wb_t expect_wb(input lsu_pkg::lsu_req_t r);
      lsu_pkg::lsu_wb_t e;
      logic [31:0]      a;
      logic [31:0]      word;
      logic [7:0]       b;
      logic [15:0]      h;
      a        = r.base + r.offset;
      e.pc     = r.pc;
      e.lsa    = a;
      e.ealign = misaligned(r.size, a);
      e.ebus   = !e.ealign && a[11];
      e.dout   = '0;
      if (r.load && !e.ealign)
      begin
         word = e.ebus ? 32'h0 : shadow[a[9:2]];
         b    = 8'(word >> {a[1:0], 3'b000});
         h    = 16'(word >> {a[1], 4'b0000});
         case (r.size)
            lsu_pkg::SIZE_BYTE: e.dout = {{24{r.sign_ext & b[7]}}, b};
            lsu_pkg::SIZE_HALF: e.dout = {{16{r.sign_ext & h[15]}}, h};
            default:            e.dout = word;
         endcase
      end
      return e;
   endfunction

   function automatic bus_xfer_t expect_xfer(input lsu_pkg::lsu_req_t r);
      bus_xfer_t   x;
      logic [31:0] a;
      a       = r.base + r.offset;
      x.write = r.store;
      x.addr  = a[ADDR_W-1:0];
      x.strb  = r.store ? lane_strobe(r.size, a) : 4'b0000;
      x.wdata = replicate(r);
      return x;
   endfunction

   task automatic update_shadow(input lsu_pkg::lsu_req_t r);
      logic [31:0]        a;
      logic [31:0]        d;
      lsu_pkg::lsu_strb_t s;
      a = r.base + r.offset;
      d = replicate(r);
      s = lane_strobe(r.size, a);
      if (r.store && !misaligned(r.size, a) && !a[11])
      begin
         for (int i = 0; i < 4; i++)
            if (s[i])
               shadow[a[9:2]][8*i +: 8] = d[8*i +: 8];
      end
   endtask

   // Random base with an offset that makes up the rest of the address
   function automatic lsu_pkg::lsu_req_t make_req(input logic store,
                                                  input lsu_pkg::lsu_size_t size,
                                                  input logic sign_ext,
                                                  input logic [31:0] addr,
                                                  input logic [31:0] wdata);
      lsu_pkg::lsu_req_t r;
      r.load     = !store;
      r.store    = store;
      r.sign_ext = sign_ext;
      r.size     = size;
      r.base     = take_bits(32);
      r.offset   = addr - r.base;
      r.wdata    = wdata;
      r.pc       = lsu_pkg::lsu_pc_t'(take_bits(30));
      return r;
   endfunction

   function automatic lsu_pkg::lsu_req_t random_req();
      logic               store;
      lsu_pkg::lsu_size_t size;
      logic               sign_ext;
      logic [31:0]        addr;
      store    = take_bits(1) != 0;
      size     = lsu_pkg::lsu_size_t'(take_bits(2));
      sign_ext = take_bits(1) != 0;
      addr     = take_bits(32);
      if (size == 2'd0)
         size = lsu_pkg::SIZE_WORD;
      // Mostly outside the error region and mostly aligned
      if (take_bits(3) != 0)
         addr[11] = 1'b0;
      if (take_bits(2) != 0)
      begin
         if (size == lsu_pkg::SIZE_WORD)
            addr[1:0] = 2'b00;
         else if (size == lsu_pkg::SIZE_HALF)
            addr[0] = 1'b0;
      end
      return make_req(store, size, sign_ext, addr, take_bits(32));
   endfunction

   // Called 0.5 ns after an edge and returns 0.5 ns after the accept edge
   task automatic send(input lsu_pkg::lsu_req_t r);
      req_valid = 1'b1;
      req       = r;
      #3;
      while (lsu_stall)
      begin
         @(posedge clk);
         #3.5;
      end
      exp_q.push_back(expect_wb(r));
      if (!misaligned(r.size, r.base + r.offset))
         bus_q.push_back(expect_xfer(r));
      update_shadow(r);
      @(posedge clk);
      #0.5;
      req_valid = 1'b0;
   endtask

   // APB transfers against the expected ones, from setup through access
   always @(negedge clk)
   begin
      bus_xfer_t x;
      if (arst_n && penable && !psel)
         stop_run("penable was high without psel");
      else if (arst_n && psel && !penable && (bus_q.size() == 0))
         stop_run("psel rose with no APB transfer expected");
      else if (arst_n && psel)
      begin
         // Transfer taken in the setup cycle and held until pready
         if (!penable)
            x = bus_q.pop_front();
         check("paddr", 32'(paddr), 32'(x.addr));
         check("pwrite", 32'(pwrite), 32'(x.write));
         check("pstrb", 32'(pstrb), 32'(x.strb));
         if (x.write)
            check("pwdata", pwdata, x.wdata);
      end
   end

   // Writeback compare
   always @(negedge clk)
   begin
      lsu_pkg::lsu_wb_t e;
      if (arst_n && wb_valid)
      begin
         if (exp_q.size() == 0)
            stop_run("wb_valid rose with no request outstanding");
         else
         begin
            e = exp_q.pop_front();
            check("wb.dout", wb.dout, e.dout);
            check("wb.pc", 32'(wb.pc), 32'(e.pc));
            check("wb.lsa", wb.lsa, e.lsa);
            check("wb.ealign", 32'(wb.ealign), 32'(e.ealign));
            check("wb.ebus", 32'(wb.ebus), 32'(e.ebus));
         end
      end
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      stop_run("Watchdog expired, the run hung before all results came back");
   end

   initial
   begin
      arst_n    = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      lfsr      = 32'hea22;
      repeat (4) @(posedge clk);
      #0.5;
      arst_n = 1'b1;
      for (int i = 0; i < 256; i++)
         shadow[i] = u_mem.mem[i];
      @(posedge clk);
      #0.5;
      check("wb_valid", 32'(wb_valid), 32'h0);
      check("psel", 32'(psel), 32'h0);
      check("penable", 32'(penable), 32'h0);
      check("lsu_stall", 32'(lsu_stall), 32'h0);

      // Word stores, then word loads from the same words
      for (int i = 0; i < 4; i++)
         send(make_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'h100 + 4 * i, take_bits(32)));
      for (int i = 0; i < 4; i++)
         send(make_req(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h100 + 4 * i, 32'h0));

      // Byte lanes, then halfwords, signed and unsigned
      for (int l = 0; l < 4; l++)
         send(make_req(1'b1, lsu_pkg::SIZE_BYTE, 1'b0, 32'h200 + l,
                       take_bits(32) | (l[0] ? 32'h80 : 32'h0)));
      for (int l = 0; l < 8; l++)
         send(make_req(1'b0, lsu_pkg::SIZE_BYTE, l[0], 32'h200 + (l >> 1), 32'h0));
      send(make_req(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 32'h206, take_bits(32) | 32'h8000));
      for (int l = 0; l < 4; l++)
         send(make_req(1'b0, lsu_pkg::SIZE_HALF, l[0], 32'h204 + 2 * (l >> 1), 32'h0));
      send(make_req(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h204, 32'h0));

      // Misaligned accesses leave memory alone
      send(make_req(1'b0, lsu_pkg::SIZE_HALF, 1'b1, 32'h301, 32'h0));
      send(make_req(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 32'h303, take_bits(32)));
      send(make_req(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h302, 32'h0));
      send(make_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'h301, take_bits(32)));
      send(make_req(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h300, 32'h0));

      // Error region
      send(make_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'h804, take_bits(32)));
      send(make_req(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h804, 32'h0));
      send(make_req(1'b0, lsu_pkg::SIZE_BYTE, 1'b1, 32'h805, 32'h0));

      for (int i = 0; i < N_RANDOM; i++)
         send(random_req());

      while (exp_q.size() != 0)
         @(posedge clk);
      repeat (4) @(posedge clk);
      if (bus_q.size() != 0)
         stop_run("APB transfers were still expected at the end of the run");
      else
      begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

// File: lsu_top.f
verilog/lsu_pkg.sv
verilog/lsu_agen.sv
verilog/lsu_apb_master.sv
verilog/lsu_load_align.sv
verilog/lsu_top.sv
bench/tb_apb_mem.sv
bench/tb_lsu_top.sv

// File: run.sh
#!/bin/sh
# Builds the load/store unit testbench with Verilator and runs it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   --top-module tb_lsu_top \
   -Mdir obj_dir \
   -o tb_lsu_top \
   -f lsu_top.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/tb_lsu_top
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi
exit 0

// File: verilog/lsu_agen.sv
// Load/store address generation
// Adds base and offset, checks alignment, replicates store data over the
// byte lanes, builds the write strobe and holds the result in a stage register

`timescale 1ns/100ps

module lsu_agen
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              req_valid,
   input  lsu_pkg::lsu_req_t req,
   output logic              lsu_stall,
   output logic              acc_valid,
   output lsu_pkg::lsu_acc_t acc,
   input  logic              acc_take
);
   lsu_pkg::lsu_data_t addr;
   lsu_pkg::lsu_data_t wdata_rep;
   lsu_pkg::lsu_strb_t strb;
   logic               misalign;
   logic               accept;

   assign addr = req.base + req.offset;

   // Word needs both low bits clear, halfword needs bit 0 clear
   assign misalign = ((req.size == lsu_pkg::SIZE_WORD) && (addr[1:0] != 2'b00)) ||
                     ((req.size == lsu_pkg::SIZE_HALF) && addr[0]);

   // Lane replication and strobe
   always_comb
   begin
      wdata_rep = req.wdata;
      strb      = 4'b0000;
      case (req.size)
         lsu_pkg::SIZE_BYTE:
         begin
            wdata_rep = {4{req.wdata[7:0]}};
            strb      = 4'b0001 << addr[1:0];
         end
         lsu_pkg::SIZE_HALF:
         begin
            wdata_rep = {2{req.wdata[15:0]}};
            strb      = addr[1] ? 4'b1100 : 4'b0011;
         end
         lsu_pkg::SIZE_WORD:
         begin
            strb = 4'b1111;
         end
         default:
         begin
            strb = 4'b0000;
         end
      endcase
      if (!req.store)
         strb = 4'b0000;
   end

   // Held entry blocks the scheduler until the bus side takes it
   assign lsu_stall = acc_valid & ~acc_take;
   assign accept    = req_valid & ~lsu_stall;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         acc_valid <= 1'b0;
      else if (accept)
         acc_valid <= 1'b1;
      else if (acc_take)
         acc_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         acc.write    <= req.store;
         acc.addr     <= addr;
         acc.strb     <= strb;
         acc.wdata    <= wdata_rep;
         acc.size     <= req.size;
         acc.sign_ext <= req.sign_ext;
         acc.pc       <= req.pc;
         acc.ealign   <= misalign;
      end
   end

endmodule

// File: verilog/lsu_apb_master.sv
// APB requester for the load/store unit
// Runs one APB transfer per stage entry, skips the bus for misaligned
// entries and presents the captured read data with the entry for one cycle

`timescale 1ns/100ps

module lsu_apb_master
#(
   parameter int ADDR_W = 12
)
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               acc_valid,
   input  lsu_pkg::lsu_acc_t  acc,
   output logic               acc_take,
   // APB requester
   output logic [ADDR_W-1:0]  paddr,
   output logic               psel,
   output logic               penable,
   output logic               pwrite,
   output lsu_pkg::lsu_data_t pwdata,
   output lsu_pkg::lsu_strb_t pstrb,
   input  logic               pready,
   input  lsu_pkg::lsu_data_t prdata,
   input  logic               pslverr,
   // Completion
   output logic               done,
   output lsu_pkg::lsu_acc_t  done_acc,
   output lsu_pkg::lsu_data_t rdata,
   output logic               ebus
);
   lsu_pkg::lsu_apb_state_e state;
   lsu_pkg::lsu_apb_state_e state_nxt;
   lsu_pkg::lsu_acc_t       cur;
   lsu_pkg::lsu_data_t      rdata_q;
   logic                    ebus_q;
   logic                    xfer_end;

   assign acc_take = (state == lsu_pkg::APB_IDLE) & acc_valid;
   assign xfer_end = (state == lsu_pkg::APB_ACCESS) & pready;

   always_comb
   begin
      state_nxt = state;
      case (state)
         lsu_pkg::APB_IDLE:
            if (acc_valid)
               state_nxt = acc.ealign ? lsu_pkg::APB_DONE : lsu_pkg::APB_SETUP;
         lsu_pkg::APB_SETUP:
            state_nxt = lsu_pkg::APB_ACCESS;
         lsu_pkg::APB_ACCESS:
            if (pready)
               state_nxt = lsu_pkg::APB_DONE;
         lsu_pkg::APB_DONE:
            state_nxt = lsu_pkg::APB_IDLE;
         default:
            state_nxt = lsu_pkg::APB_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         state <= lsu_pkg::APB_IDLE;
      else
         state <= state_nxt;
   end

   // Entry stays put for the whole transfer
   always_ff @(posedge clk)
   begin
      if (acc_take)
         cur <= acc;
   end

   always_ff @(posedge clk)
   begin
      if (xfer_end)
         rdata_q <= prdata;
   end

   // Misaligned entries never see the bus, so the flag starts clear
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         ebus_q <= 1'b0;
      else if (acc_take)
         ebus_q <= 1'b0;
      else if (xfer_end)
         ebus_q <= pslverr;
   end

   assign psel    = (state == lsu_pkg::APB_SETUP) | (state == lsu_pkg::APB_ACCESS);
   assign penable = (state == lsu_pkg::APB_ACCESS);
   assign paddr   = cur.addr[ADDR_W-1:0];
   assign pwrite  = cur.write;
   assign pwdata  = cur.wdata;
   assign pstrb   = cur.strb;

   assign done     = (state == lsu_pkg::APB_DONE);
   assign done_acc = cur;
   assign rdata    = rdata_q;
   assign ebus     = ebus_q;

endmodule

// File: verilog/lsu_load_align.sv
// Load result alignment and writeback register
// Picks the addressed byte or halfword from the read word, extends it with
// sign or zeros and registers the writeback record for one cycle

`timescale 1ns/100ps

module lsu_load_align
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               done,
   input  lsu_pkg::lsu_acc_t  done_acc,
   input  lsu_pkg::lsu_data_t rdata,
   input  logic               ebus,
   output logic               wb_valid,
   output lsu_pkg::lsu_wb_t   wb
);
   logic [7:0]         dout_8b;
   logic [15:0]        dout_16b;
   lsu_pkg::lsu_data_t dout;

   // Lane select
   always_comb
   begin
      case (done_acc.addr[1:0])
         2'b00:   dout_8b = rdata[7:0];
         2'b01:   dout_8b = rdata[15:8];
         2'b10:   dout_8b = rdata[23:16];
         default: dout_8b = rdata[31:24];
      endcase
   end

   assign dout_16b = done_acc.addr[1] ? rdata[31:16] : rdata[15:0];

   always_comb
   begin
      case (done_acc.size)
         lsu_pkg::SIZE_BYTE:
            dout = {{24{done_acc.sign_ext & dout_8b[7]}}, dout_8b};
         lsu_pkg::SIZE_HALF:
            dout = {{16{done_acc.sign_ext & dout_16b[15]}}, dout_16b};
         lsu_pkg::SIZE_WORD:
            dout = rdata;
         default:
            dout = '0;
      endcase
      // Stores and misaligned accesses return no data
      if (done_acc.write || done_acc.ealign)
         dout = '0;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         wb_valid <= 1'b0;
      else
         wb_valid <= done;
   end

   always_ff @(posedge clk)
   begin
      if (done)
      begin
         wb.dout   <= dout;
         wb.pc     <= done_acc.pc;
         wb.lsa    <= done_acc.addr;
         wb.ealign <= done_acc.ealign;
         wb.ebus   <= ebus;
      end
   end

endmodule

// File: verilog/lsu_pkg.sv
// Load/store unit shared types
// Data, strobe, size and PC vectors, the scheduler request, the stage entry,
// the writeback record and the APB requester state encoding

package lsu_pkg;

   // Plain vectors
   typedef logic [31:0] lsu_data_t;
   typedef logic [3:0]  lsu_strb_t;
   typedef logic [1:0]  lsu_size_t;
   typedef logic [29:0] lsu_pc_t;

   // Access size codes
   localparam lsu_size_t SIZE_BYTE = 2'd1;
   localparam lsu_size_t SIZE_HALF = 2'd2;
   localparam lsu_size_t SIZE_WORD = 2'd3;

   // Request from the scheduler
   typedef struct packed {
      logic      load;
      logic      store;
      logic      sign_ext;
      lsu_size_t size;
      lsu_data_t base;
      lsu_data_t offset;
      lsu_data_t wdata;
      lsu_pc_t   pc;
   } lsu_req_t;

   // Stage entry from address generation to the bus side
   typedef struct packed {
      logic      write;
      lsu_data_t addr;
      lsu_strb_t strb;     // zero for loads
      lsu_data_t wdata;    // already replicated across lanes
      lsu_size_t size;
      logic      sign_ext;
      lsu_pc_t   pc;
      logic      ealign;
   } lsu_acc_t;

   // Writeback record
   typedef struct packed {
      lsu_data_t dout;
      lsu_pc_t   pc;
      lsu_data_t lsa;
      logic      ealign;
      logic      ebus;
   } lsu_wb_t;

   typedef enum logic [1:0] {
      APB_IDLE,
      APB_SETUP,
      APB_ACCESS,
      APB_DONE
   } lsu_apb_state_e;

endpackage

// File: verilog/lsu_top.sv
// Load/store unit top level
// Address generation, APB requester and load alignment in a row

`timescale 1ns/100ps

module lsu_top
#(
   parameter int ADDR_W = 12
)
(
   input  logic               clk,
   input  logic               arst_n,
   // Scheduler
   input  logic               req_valid,
   input  lsu_pkg::lsu_req_t  req,
   output logic               lsu_stall,
   // APB requester
   output logic [ADDR_W-1:0]  paddr,
   output logic               psel,
   output logic               penable,
   output logic               pwrite,
   output lsu_pkg::lsu_data_t pwdata,
   output lsu_pkg::lsu_strb_t pstrb,
   input  logic               pready,
   input  lsu_pkg::lsu_data_t prdata,
   input  logic               pslverr,
   // Writeback
   output logic               wb_valid,
   output lsu_pkg::lsu_wb_t   wb
);
   logic               acc_valid;
   logic               acc_take;
   lsu_pkg::lsu_acc_t  acc;
   logic               done;
   lsu_pkg::lsu_acc_t  done_acc;
   lsu_pkg::lsu_data_t rdata;
   logic               ebus;

   lsu_agen u_agen
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .req_valid (req_valid),
      .req       (req),
      .lsu_stall (lsu_stall),
      .acc_valid (acc_valid),
      .acc       (acc),
      .acc_take  (acc_take)
   );

   lsu_apb_master #(.ADDR_W(ADDR_W)) u_apb
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .acc_valid (acc_valid),
      .acc       (acc),
      .acc_take  (acc_take),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .pstrb     (pstrb),
      .pready    (pready),
      .prdata    (prdata),
      .pslverr   (pslverr),
      .done      (done),
      .done_acc  (done_acc),
      .rdata     (rdata),
      .ebus      (ebus)
   );

   lsu_load_align u_align
   (
      .clk      (clk),
      .arst_n   (arst_n),
      .done     (done),
      .done_acc (done_acc),
      .rdata    (rdata),
      .ebus     (ebus),
      .wb_valid (wb_valid),
      .wb       (wb)
   );

endmodule
